// File: rtl/vgachargen_defines.svh
`ifndef VGACHARGEN_DEFINES_SVH
`define VGACHARGEN_DEFINES_SVH

// horizontal timing in pixels
`define VGA_HD  10'd640
`define VGA_HF  10'd16
`define VGA_HSW 10'd96
`define VGA_HB  10'd48

// vertical timing in lines
`define VGA_VD  10'd480
`define VGA_VF  10'd10
`define VGA_VSW 10'd2
`define VGA_VB  10'd33

// clk_i cycles per pixel
`define VGA_CLK_DIV 4

// text grid
`define TEXT_COLS 80

// glyph cell size in pixels
`define GLYPH_W 8
`define GLYPH_H 16

// word address of the char and colour maps
`define TEXT_ADDR_W 10

// glyph code, also the font address
`define FONT_ADDR_W 8

`endif

// File: rtl/vgachargen_pkg.sv
`include "vgachargen_defines.svh"

package vgachargen_pkg;

  typedef logic [9:0] hcount_t;
  typedef logic [9:0] vcount_t;

  // row * cols + col over the visible grid
  typedef logic [$clog2(`TEXT_COLS * (`VGA_VD / `GLYPH_H))-1:0] cell_addr_t;

  typedef logic [`TEXT_ADDR_W-1:0]         text_addr_t;
  typedef logic [31:0]                     text_word_t;
  typedef logic [3:0]                      byte_en_t;
  typedef logic [`FONT_ADDR_W-1:0]         glyph_code_t;
  typedef logic [`GLYPH_W*`GLYPH_H-1:0]    glyph_bits_t; // row * 8 + col
  typedef logic [$clog2(`GLYPH_W*`GLYPH_H)-1:0] glyph_bit_idx_t;
  typedef logic [3:0]                      color_code_t;

  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
  } rgb_t;

  typedef struct packed {
    logic       we;
    byte_en_t   be;
    text_addr_t addr;
    text_word_t wdata;
  } text_wr_t;

  typedef struct packed {
    logic        we;
    glyph_code_t addr;
    glyph_bits_t wdata;
  } font_wr_t;

  typedef enum logic [1:0] {
    DISPLAY,
    FRONT,
    SYNC,
    BACK
  } timing_state_e;

  // bit 3 is intensity and bits 2..0 enable r g b
  function automatic rgb_t color_decode(color_code_t code);
    logic [3:0] lvl_on;
    logic [3:0] lvl_off;
    rgb_t       c;
    lvl_on  = code[3] ? 4'hF : 4'hA;
    lvl_off = code[3] ? 4'h5 : 4'h0;
    c.r     = code[2] ? lvl_on : lvl_off;
    c.g     = code[1] ? lvl_on : lvl_off;
    c.b     = code[0] ? lvl_on : lvl_off;
    return c;
  endfunction

endpackage

// File: rtl/vga_timing.sv
`timescale 1ns/1ps
`include "vgachargen_defines.svh"

module vga_timing (
  input  logic                    clk_i,
  input  logic                    arstn_i,
  output vgachargen_pkg::hcount_t hcount_o,
  output vgachargen_pkg::vcount_t vcount_o,
  output logic                    pixel_en_o,
  output logic                    hs_o,
  output logic                    vs_o
);

  localparam int unsigned DIV_W = $clog2(`VGA_CLK_DIV);

  localparam vgachargen_pkg::hcount_t H_DISP_END  = `VGA_HD - 1;
  localparam vgachargen_pkg::hcount_t H_FRONT_END = `VGA_HD + `VGA_HF - 1;
  localparam vgachargen_pkg::hcount_t H_SYNC_END  = `VGA_HD + `VGA_HF + `VGA_HSW - 1;
  localparam vgachargen_pkg::hcount_t H_LAST      = `VGA_HD + `VGA_HF + `VGA_HSW + `VGA_HB - 1;

  localparam vgachargen_pkg::vcount_t V_DISP_END  = `VGA_VD - 1;
  localparam vgachargen_pkg::vcount_t V_FRONT_END = `VGA_VD + `VGA_VF - 1;
  localparam vgachargen_pkg::vcount_t V_SYNC_END  = `VGA_VD + `VGA_VF + `VGA_VSW - 1;
  localparam vgachargen_pkg::vcount_t V_LAST      = `VGA_VD + `VGA_VF + `VGA_VSW + `VGA_VB - 1;

  logic [DIV_W-1:0]              div_cnt_q;
  logic                          pixel_stb;
  vgachargen_pkg::hcount_t       hcount_q;
  vgachargen_pkg::vcount_t       vcount_q;
  logic                          h_last;
  logic                          v_step;
  vgachargen_pkg::timing_state_e hstate_q;
  vgachargen_pkg::timing_state_e hstate_d;
  vgachargen_pkg::timing_state_e vstate_q;
  vgachargen_pkg::timing_state_e vstate_d;
  logic                          hs_q;
  logic                          vs_q;
  logic                          pixel_en_q;

  // one pixel strobe every VGA_CLK_DIV clocks
  always_ff @(posedge clk_i or negedge arstn_i) begin
    if (!arstn_i) begin
      div_cnt_q <= '0;
    end else if (div_cnt_q == '0) begin
      div_cnt_q <= DIV_W'(`VGA_CLK_DIV - 1);
    end else begin
      div_cnt_q <= div_cnt_q - 1'b1;
    end
  end

  assign pixel_stb = (div_cnt_q == '0);
  assign h_last    = (hcount_q == H_LAST);
  assign v_step    = pixel_stb & h_last; // end of line

  always_comb begin
    hstate_d = hstate_q;
    unique case (hstate_q)
      vgachargen_pkg::DISPLAY: if (hcount_q == H_DISP_END)  hstate_d = vgachargen_pkg::FRONT;
      vgachargen_pkg::FRONT:   if (hcount_q == H_FRONT_END) hstate_d = vgachargen_pkg::SYNC;
      vgachargen_pkg::SYNC:    if (hcount_q == H_SYNC_END)  hstate_d = vgachargen_pkg::BACK;
      vgachargen_pkg::BACK:    if (h_last)                  hstate_d = vgachargen_pkg::DISPLAY;
      default:                                              hstate_d = vgachargen_pkg::DISPLAY;
    endcase
  end

  always_comb begin
    vstate_d = vstate_q;
    if (h_last) begin // vertical moves only at line end
      unique case (vstate_q)
        vgachargen_pkg::DISPLAY: if (vcount_q == V_DISP_END)  vstate_d = vgachargen_pkg::FRONT;
        vgachargen_pkg::FRONT:   if (vcount_q == V_FRONT_END) vstate_d = vgachargen_pkg::SYNC;
        vgachargen_pkg::SYNC:    if (vcount_q == V_SYNC_END)  vstate_d = vgachargen_pkg::BACK;
        vgachargen_pkg::BACK:    if (vcount_q == V_LAST)      vstate_d = vgachargen_pkg::DISPLAY;
        default:                                              vstate_d = vgachargen_pkg::DISPLAY;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge arstn_i) begin
    if (!arstn_i) begin
      hcount_q   <= '0;
      vcount_q   <= '0;
      hstate_q   <= vgachargen_pkg::DISPLAY;
      vstate_q   <= vgachargen_pkg::DISPLAY;
      hs_q       <= 1'b1;
      vs_q       <= 1'b1;
      pixel_en_q <= 1'b0;
    end else if (pixel_stb) begin
      hcount_q   <= h_last ? '0 : hcount_q + 1'b1;
      hstate_q   <= hstate_d;
      vstate_q   <= vstate_d;
      hs_q       <= (hstate_d != vgachargen_pkg::SYNC); // active low
      vs_q       <= (vstate_d != vgachargen_pkg::SYNC);
      pixel_en_q <= (hstate_d == vgachargen_pkg::DISPLAY) &&
                    (vstate_d == vgachargen_pkg::DISPLAY);
      if (v_step) begin
        vcount_q <= (vcount_q == V_LAST) ? '0 : vcount_q + 1'b1;
      end
    end
  end

  assign hcount_o   = hcount_q;
  assign vcount_o   = vcount_q;
  assign hs_o       = hs_q;
  assign vs_o       = vs_q;
  assign pixel_en_o = pixel_en_q;

endmodule

// File: rtl/byte_lane_ram.sv
`timescale 1ns/1ps

module byte_lane_ram #(
  parameter int unsigned NUM_LANES = 4,
  parameter int unsigned LANE_W    = 8,
  parameter int unsigned ADDR_W    = 10
) (
  input  logic                        clk_i,
  input  logic [ADDR_W-1:0]           a_addr_i,
  input  logic [NUM_LANES-1:0]        a_be_i,
  input  logic [NUM_LANES*LANE_W-1:0] a_wdata_i,
  output logic [NUM_LANES*LANE_W-1:0] a_rdata_o,
  input  logic [ADDR_W-1:0]           b_addr_i,
  output logic [NUM_LANES*LANE_W-1:0] b_rdata_o
);

  localparam int unsigned DEPTH = 2 ** ADDR_W;

  logic [NUM_LANES-1:0][LANE_W-1:0] mem [DEPTH];
  logic [NUM_LANES-1:0][LANE_W-1:0] a_merged;

  initial begin
    for (int unsigned i = 0; i < DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  // port A shows the written word on the write edge
  always_comb begin
    a_merged = mem[a_addr_i];
    for (int i = 0; i < NUM_LANES; i++) begin
      if (a_be_i[i]) a_merged[i] = a_wdata_i[i*LANE_W +: LANE_W];
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NUM_LANES; i++) begin
      if (a_be_i[i]) mem[a_addr_i][i] <= a_wdata_i[i*LANE_W +: LANE_W];
    end
    a_rdata_o <= a_merged;
  end

  always_ff @(posedge clk_i) begin
    b_rdata_o <= mem[b_addr_i]; // video read port
  end

endmodule

// File: rtl/glyph_pixel_pipe.sv
`timescale 1ns/1ps
`include "vgachargen_defines.svh"

module glyph_pixel_pipe (
  input  logic                        clk_i,
  input  logic                        arstn_i,
  input  vgachargen_pkg::hcount_t     hcount_i,
  input  vgachargen_pkg::vcount_t     vcount_i,
  input  logic                        pixel_en_i,
  input  logic                        hs_i,
  input  logic                        vs_i,
  output vgachargen_pkg::text_addr_t  text_addr_o,
  input  vgachargen_pkg::text_word_t  char_word_i,
  input  vgachargen_pkg::text_word_t  col_word_i,
  output vgachargen_pkg::glyph_code_t font_addr_o,
  input  vgachargen_pkg::glyph_bits_t glyph_i,
  output vgachargen_pkg::rgb_t        rgb_o,
  output logic                        hs_o,
  output logic                        vs_o
);

  localparam int unsigned COL_SHIFT = $clog2(`GLYPH_W);
  localparam int unsigned ROW_SHIFT = $clog2(`GLYPH_H);

  typedef struct packed {
    logic hs;
    logic vs;
    logic pixel_en;
  } video_flags_t;

  localparam video_flags_t FLAGS_IDLE = '{hs: 1'b1, vs: 1'b1, pixel_en: 1'b0};

  vgachargen_pkg::cell_addr_t     cell_row;
  vgachargen_pkg::cell_addr_t     cell_col;
  vgachargen_pkg::cell_addr_t     cell_idx;
  vgachargen_pkg::glyph_bit_idx_t bit_idx;
  video_flags_t                   flags_in;

  logic [1:0]                     lane_q1;
  vgachargen_pkg::glyph_bit_idx_t bit_idx_q1;
  vgachargen_pkg::glyph_bit_idx_t bit_idx_q2;
  video_flags_t                   flags_q1;
  video_flags_t                   flags_q2;
  logic [7:0]                     col_byte;
  logic [7:0]                     col_byte_q2;

  logic                           glyph_bit;
  vgachargen_pkg::rgb_t           fg_rgb;
  vgachargen_pkg::rgb_t           bg_rgb;
  vgachargen_pkg::rgb_t           rgb_q;
  logic                           hs_q;
  logic                           vs_q;

  // index generation
  assign cell_row = vgachargen_pkg::cell_addr_t'(vcount_i >> ROW_SHIFT);
  assign cell_col = vgachargen_pkg::cell_addr_t'(hcount_i >> COL_SHIFT);
  assign cell_idx = (cell_row << 6) + (cell_row << 4) + cell_col; // row * 80
  assign bit_idx  = {vcount_i[ROW_SHIFT-1:0], hcount_i[COL_SHIFT-1:0]};

  assign text_addr_o = cell_idx[$bits(cell_idx)-1:2];
  assign flags_in    = '{hs: hs_i, vs: vs_i, pixel_en: pixel_en_i};

  // map words are valid one clock after text_addr_o
  assign font_addr_o = char_word_i[{lane_q1, 3'b000} +: 8];
  assign col_byte    = col_word_i[{lane_q1, 3'b000} +: 8];

  always_ff @(posedge clk_i) begin
    lane_q1     <= cell_idx[1:0];
    bit_idx_q1  <= bit_idx;
    bit_idx_q2  <= bit_idx_q1;
    col_byte_q2 <= col_byte; // lines up with glyph_i
  end

  always_ff @(posedge clk_i or negedge arstn_i) begin
    if (!arstn_i) begin
      flags_q1 <= FLAGS_IDLE;
      flags_q2 <= FLAGS_IDLE;
    end else begin
      flags_q1 <= flags_in;
      flags_q2 <= flags_q1;
    end
  end

  assign glyph_bit = glyph_i[bit_idx_q2];
  assign fg_rgb    = vgachargen_pkg::color_decode(col_byte_q2[7:4]);
  assign bg_rgb    = vgachargen_pkg::color_decode(col_byte_q2[3:0]);

  always_ff @(posedge clk_i or negedge arstn_i) begin
    if (!arstn_i) begin
      rgb_q <= '0;
      hs_q  <= 1'b1;
      vs_q  <= 1'b1;
    end else begin
      rgb_q <= flags_q2.pixel_en ? (glyph_bit ? fg_rgb : bg_rgb) : '0; // blank off screen
      hs_q  <= flags_q2.hs;
      vs_q  <= flags_q2.vs;
    end
  end

  assign rgb_o = rgb_q;
  assign hs_o  = hs_q;
  assign vs_o  = vs_q;

endmodule

// File: rtl/vgachargen.sv
`timescale 1ns/1ps
`include "vgachargen_defines.svh"

module vgachargen (
  input  logic                       clk_i,
  input  logic                       arstn_i,
  input  vgachargen_pkg::text_wr_t   char_wr_i,
  input  vgachargen_pkg::text_wr_t   col_wr_i,
  input  vgachargen_pkg::font_wr_t   font_wr_i,
  output vgachargen_pkg::text_word_t char_rdata_o,
  output vgachargen_pkg::text_word_t col_rdata_o,
  output vgachargen_pkg::rgb_t       vga_rgb_o,
  output logic                       vga_hs_o,
  output logic                       vga_vs_o
);

  localparam int unsigned TEXT_LANES = $bits(vgachargen_pkg::byte_en_t);

  vgachargen_pkg::hcount_t     hcount;
  vgachargen_pkg::vcount_t     vcount;
  logic                        pixel_en;
  logic                        hs;
  logic                        vs;
  vgachargen_pkg::text_addr_t  text_addr;
  vgachargen_pkg::text_word_t  char_word;
  vgachargen_pkg::text_word_t  col_word;
  vgachargen_pkg::glyph_code_t font_addr;
  vgachargen_pkg::glyph_bits_t glyph;
  vgachargen_pkg::byte_en_t    char_be;
  vgachargen_pkg::byte_en_t    col_be;

  assign char_be = char_wr_i.be & {TEXT_LANES{char_wr_i.we}};
  assign col_be  = col_wr_i.be & {TEXT_LANES{col_wr_i.we}};

  vga_timing i_vga_timing (
    .clk_i      (clk_i),
    .arstn_i    (arstn_i),
    .hcount_o   (hcount),
    .vcount_o   (vcount),
    .pixel_en_o (pixel_en),
    .hs_o       (hs),
    .vs_o       (vs)
  );

  byte_lane_ram #(
    .NUM_LANES (TEXT_LANES),
    .LANE_W    (8),
    .ADDR_W    (`TEXT_ADDR_W)
  ) i_char_map (
    .clk_i     (clk_i),
    .a_addr_i  (char_wr_i.addr),
    .a_be_i    (char_be),
    .a_wdata_i (char_wr_i.wdata),
    .a_rdata_o (char_rdata_o),
    .b_addr_i  (text_addr),
    .b_rdata_o (char_word)
  );

  byte_lane_ram #(
    .NUM_LANES (TEXT_LANES),
    .LANE_W    (8),
    .ADDR_W    (`TEXT_ADDR_W)
  ) i_col_map (
    .clk_i     (clk_i),
    .a_addr_i  (col_wr_i.addr),
    .a_be_i    (col_be),
    .a_wdata_i (col_wr_i.wdata),
    .a_rdata_o (col_rdata_o),
    .b_addr_i  (text_addr),
    .b_rdata_o (col_word)
  );

  // whole glyph written at once
  byte_lane_ram #(
    .NUM_LANES (1),
    .LANE_W    (`GLYPH_W * `GLYPH_H),
    .ADDR_W    (`FONT_ADDR_W)
  ) i_font_mem (
    .clk_i     (clk_i),
    .a_addr_i  (font_wr_i.addr),
    .a_be_i    (font_wr_i.we),
    .a_wdata_i (font_wr_i.wdata),
    .a_rdata_o (),
    .b_addr_i  (font_addr),
    .b_rdata_o (glyph)
  );

  glyph_pixel_pipe i_glyph_pixel_pipe (
    .clk_i       (clk_i),
    .arstn_i     (arstn_i),
    .hcount_i    (hcount),
    .vcount_i    (vcount),
    .pixel_en_i  (pixel_en),
    .hs_i        (hs),
    .vs_i        (vs),
    .text_addr_o (text_addr),
    .char_word_i (char_word),
    .col_word_i  (col_word),
    .font_addr_o (font_addr),
    .glyph_i     (glyph),
    .rgb_o       (vga_rgb_o),
    .hs_o        (vga_hs_o),
    .vs_o        (vga_vs_o)
  );

endmodule

// File: tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic arstn_o
);

  initial begin
    clk_o   = 1'b0;
    arstn_o = 1'b0;
    forever #10 clk_o = ~clk_o; // 20 ns period
  end

  initial begin
    repeat (4) @(posedge clk_o);
    @(negedge clk_o);
    arstn_o = 1'b1;
  end

endmodule

// File: tests/vgachargen_checker.sv
`timescale 1ns/1ps
`include "vgachargen_defines.svh"

module vgachargen_checker (
  input  logic                       clk_i,
  input  logic                       arstn_i,
  input  vgachargen_pkg::text_wr_t   char_wr_i,
  input  vgachargen_pkg::text_wr_t   col_wr_i,
  input  vgachargen_pkg::text_word_t char_rdata_i,
  input  vgachargen_pkg::text_word_t col_rdata_i,
  input  vgachargen_pkg::rgb_t       rgb_i,
  input  logic                       hs_i,
  input  logic                       vs_i,
  output logic                       done_o,
  output int                         errors_o
);

  localparam int T_RESET = 0;
  localparam int T_CHAR  = 1;
  localparam int T_COL   = 2;
  localparam int T_HS    = 3;
  localparam int T_VS    = 4;
  localparam int T_BLANK = 5;
  localparam int T_GLYPH = 6;
  localparam int NT      = 10;
  localparam longint H_CLKS = 800 * `VGA_CLK_DIV;

  string      names [NT] = '{"reset_values", "char_map_bus", "col_map_bus", "hs_timing",
                             "vs_timing", "blanking", "cell_r0_c0", "cell_r0_c3",
                             "cell_r2_c41", "cell_r29_c79"};
  int         g_row [4] = '{0, 0, 2, 29};
  int         g_col [4] = '{0, 3, 41, 79};
  logic [7:0] g_color [4] = '{8'h1E, 8'hF0, 8'h9A, 8'h4C};
  logic [7:0] g_pat [4] = '{8'hA5, 8'h3C, 8'h81, 8'hF0};

  int          checks [NT];
  int          fails [NT];
  logic [31:0] char_model [1024];
  logic [31:0] col_model [1024];
  logic [31:0] exp_char;
  logic [31:0] exp_col;
  logic        exp_valid;
  longint      cyc;
  longint      hs_fall_t;
  longint      hs_seen;
  longint      vs_fall_t;
  int          vs_falls;
  int          hs_since_vs;
  logic        hs_prev;
  logic        vs_prev;

  function automatic logic [3:0] channel_level(logic bright, logic on);
    case ({bright, on})
      2'b11:   return 4'hF;
      2'b01:   return 4'hA;
      2'b10:   return 4'h5;
      default: return 4'h0;
    endcase
  endfunction

  function automatic logic [11:0] palette_rgb(logic [3:0] code);
    return {channel_level(code[3], code[2]), channel_level(code[3], code[1]),
            channel_level(code[3], code[0])};
  endfunction

  function automatic logic [31:0] merge_write(logic [31:0] old, vgachargen_pkg::text_wr_t wr);
    logic [31:0] w;
    w = old;
    for (int i = 0; i < 4; i++) begin
      if (wr.we && wr.be[i]) w[i*8 +: 8] = wr.wdata[i*8 +: 8];
    end
    return w;
  endfunction

  task automatic check(input int t, input logic ok, input logic [31:0] exp,
                       input logic [31:0] act);
    checks[t]++;
    if (!ok) begin
      fails[t]++;
      if (fails[t] <= 10) begin
        $display("ERROR %s expected %h actual %h at %0t", names[t], exp, act, $time);
      end
    end
  endtask

  task automatic report_all();
    int total;
    int ran;
    total = 0;
    ran   = 0;
    for (int t = 0; t < NT; t++) begin
      ran += checks[t];
      if (checks[t] == 0) begin
        $display("%s: no samples were taken, so the test did not run", names[t]);
        total++;
      end else begin
        $display("%s: %0d checks, %0d errors", names[t], checks[t], fails[t]);
        total += fails[t];
      end
    end
    $display("tests %0d, checks %0d, errors %0d", NT, ran, total);
    errors_o = total;
  endtask

  initial begin
    done_o      = 1'b0;
    errors_o    = 0;
    exp_valid   = 1'b0;
    cyc         = 0;
    hs_seen     = 0;
    vs_falls    = 0;
    hs_since_vs = 0;
    hs_prev     = 1'b1;
    vs_prev     = 1'b1;
    for (int t = 0; t < NT; t++) begin
      checks[t] = 0;
      fails[t]  = 0;
    end
    for (int i = 0; i < 1024; i++) begin
      char_model[i] = '0;
      col_model[i]  = '0;
    end
  end

  // rdata follows the bus address one clock later
  always @(posedge clk_i) begin
    if (arstn_i) begin
      char_model[char_wr_i.addr] = merge_write(char_model[char_wr_i.addr], char_wr_i);
      col_model[col_wr_i.addr]   = merge_write(col_model[col_wr_i.addr], col_wr_i);
      exp_char  = char_model[char_wr_i.addr];
      exp_col   = col_model[col_wr_i.addr];
      exp_valid = 1'b1;
    end
  end

  always @(negedge clk_i) begin
    longint hpos;
    int     pix;
    int     x;
    int     y;
    logic [7:0]  rowbits;
    logic [11:0] exp_rgb;
    cyc++;
    if (!arstn_i) begin
      check(T_RESET, {hs_i, vs_i, rgb_i} === 14'h3000, 32'h0000_3000, {hs_i, vs_i, rgb_i});
    end else if (!done_o) begin
      if (exp_valid) begin
        check(T_CHAR, char_rdata_i === exp_char, exp_char, char_rdata_i);
        check(T_COL, col_rdata_i === exp_col, exp_col, col_rdata_i);
      end
      if (hs_prev && !hs_i) begin
        if (hs_seen > 0) check(T_HS, cyc - hs_fall_t == H_CLKS, H_CLKS, cyc - hs_fall_t);
        hs_fall_t = cyc;
        hs_seen++;
        hs_since_vs++;
      end
      if (!hs_prev && hs_i && hs_seen > 0) begin
        check(T_HS, cyc - hs_fall_t == 96 * `VGA_CLK_DIV, 96 * `VGA_CLK_DIV, cyc - hs_fall_t);
      end
      if (!vs_prev && vs_i && vs_falls > 0) begin
        check(T_VS, cyc - vs_fall_t == 2 * H_CLKS, 2 * H_CLKS, cyc - vs_fall_t);
      end
      if (vs_prev && !vs_i) begin
        if (vs_falls > 0) begin
          check(T_VS, cyc - vs_fall_t == 525 * H_CLKS, 525 * H_CLKS, cyc - vs_fall_t);
          report_all();
          done_o = 1'b1;
        end
        vs_fall_t   = cyc;
        vs_falls++;
        hs_since_vs = 0;
      end
      if (hs_seen > 0 && !done_o) begin
        hpos = cyc - hs_fall_t;
        pix  = int'((656 + hpos / `VGA_CLK_DIV) % 800);
        if (!hs_i || !vs_i || pix >= 640) begin
          check(T_BLANK, rgb_i === '0, 32'h0, rgb_i);
        end
        // lines 0..479 of the frame after the first vsync
        if (vs_falls == 1 && hpos / `VGA_CLK_DIV >= 144 && hpos % `VGA_CLK_DIV == 2) begin
          x = pix;
          y = (490 + hs_since_vs) % 525;
          if (hs_since_vs >= 35 && y < 480) begin
            for (int g = 0; g < 4; g++) begin
              if (y / 16 == g_row[g] && x / 8 == g_col[g]) begin
                rowbits = (y % 2 == 1) ? ~g_pat[g] : g_pat[g];
                exp_rgb = rowbits[x % 8] ? palette_rgb(g_color[g][7:4]) :
                                           palette_rgb(g_color[g][3:0]);
                check(T_GLYPH + g, rgb_i === exp_rgb, exp_rgb, rgb_i);
              end
            end
          end
        end
      end
    end
    hs_prev = hs_i;
    vs_prev = vs_i;
  end

endmodule

// File: tests/vgachargen_tb.sv
`timescale 1ns/1ps
`include "vgachargen_defines.svh"

module vgachargen_tb;

  localparam int NUM_CELLS = 4;
  localparam longint WATCHDOG_NS = 3 * 800 * 525 * `VGA_CLK_DIV * 20;

  logic                       clk;
  logic                       arstn;
  vgachargen_pkg::text_wr_t   char_wr;
  vgachargen_pkg::text_wr_t   col_wr;
  vgachargen_pkg::font_wr_t   font_wr;
  vgachargen_pkg::text_word_t char_rdata;
  vgachargen_pkg::text_word_t col_rdata;
  vgachargen_pkg::rgb_t       vga_rgb;
  logic                       vga_hs;
  logic                       vga_vs;
  logic                       done;
  int                         errors;
  logic [15:0]                lfsr_q;

  // row, col, glyph code, colour byte, glyph row pattern
  int         cell_row [NUM_CELLS] = '{0, 0, 2, 29};
  int         cell_col [NUM_CELLS] = '{0, 3, 41, 79};
  logic [7:0] cell_code [NUM_CELLS] = '{8'h41, 8'h42, 8'h43, 8'h44};
  logic [7:0] cell_color [NUM_CELLS] = '{8'h1E, 8'hF0, 8'h9A, 8'h4C};
  logic [7:0] cell_pat [NUM_CELLS] = '{8'hA5, 8'h3C, 8'h81, 8'hF0};

  tb_clock_gen i_tb_clock_gen (
    .clk_o   (clk),
    .arstn_o (arstn)
  );

  vgachargen i_vgachargen (
    .clk_i        (clk),
    .arstn_i      (arstn),
    .char_wr_i    (char_wr),
    .col_wr_i     (col_wr),
    .font_wr_i    (font_wr),
    .char_rdata_o (char_rdata),
    .col_rdata_o  (col_rdata),
    .vga_rgb_o    (vga_rgb),
    .vga_hs_o     (vga_hs),
    .vga_vs_o     (vga_vs)
  );

  vgachargen_checker i_vgachargen_checker (
    .clk_i        (clk),
    .arstn_i      (arstn),
    .char_wr_i    (char_wr),
    .col_wr_i     (col_wr),
    .char_rdata_i (char_rdata),
    .col_rdata_i  (col_rdata),
    .rgb_i        (vga_rgb),
    .hs_i         (vga_hs),
    .vs_i         (vga_vs),
    .done_o       (done),
    .errors_o     (errors)
  );

  // fibonacci lfsr with taps 16 14 13 11
  function automatic logic lfsr_bit();
    logic fb;
    fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    lfsr_q = {lfsr_q[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] lfsr_word();
    logic [31:0] w;
    for (int i = 0; i < 32; i++) begin
      w[i] = lfsr_bit();
    end
    return w;
  endfunction

  task automatic write_char(input logic we, input logic [3:0] be, input int addr,
                            input logic [31:0] data);
    char_wr = '{we: we, be: be, addr: addr[9:0], wdata: data};
    @(negedge clk);
    char_wr.we = 1'b0;
  endtask

  task automatic write_col(input logic we, input logic [3:0] be, input int addr,
                           input logic [31:0] data);
    col_wr = '{we: we, be: be, addr: addr[9:0], wdata: data};
    @(negedge clk);
    col_wr.we = 1'b0;
  endtask

  task automatic write_font(input logic [7:0] code, input logic [7:0] pat);
    logic [127:0] bits;
    for (int r = 0; r < 16; r++) begin
      bits[r*8 +: 8] = r[0] ? ~pat : pat; // odd rows inverted
    end
    font_wr = '{we: 1'b1, addr: code, wdata: bits};
    @(negedge clk);
    font_wr.we = 1'b0;
  endtask

  initial begin
    int idx;
    lfsr_q  = 16'd90;
    char_wr = '0;
    col_wr  = '0;
    font_wr = '0;
    wait (arstn === 1'b1);
    @(negedge clk);
    // bus read-back at a word outside the visible grid
    write_char(1'b1, 4'hF, 1000, lfsr_word());
    write_char(1'b1, 4'b0101, 1000, lfsr_word());
    repeat (2) @(negedge clk);
    write_col(1'b1, 4'hF, 1000, lfsr_word());
    write_col(1'b1, 4'b1010, 1000, lfsr_word());
    write_col(1'b0, 4'hF, 1000, lfsr_word());
    repeat (2) @(negedge clk);
    for (int i = 0; i < NUM_CELLS; i++) begin
      idx = cell_row[i] * 80 + cell_col[i];
      write_font(cell_code[i], cell_pat[i]);
      write_char(1'b1, 4'b0001 << idx[1:0], idx >> 2,
                 {24'h0, cell_code[i]} << (idx[1:0] * 8));
      write_col(1'b1, 4'b0001 << idx[1:0], idx >> 2,
                {24'h0, cell_color[i]} << (idx[1:0] * 8));
    end
    wait (done === 1'b1);
    @(negedge clk);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the video frames did not complete in time");
    $display("Finished with errors");
    $finish;
  end

endmodule

// File: vgachargen.f
+incdir+rtl
rtl/vgachargen_pkg.sv
rtl/vga_timing.sv
rtl/byte_lane_ram.sv
rtl/glyph_pixel_pipe.sv
rtl/vgachargen.sv
tests/tb_clock_gen.sv
tests/vgachargen_checker.sv
tests/vgachargen_tb.sv

// File: Bender.yml
package:
  name: vgachargen

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/vgachargen_pkg.sv
      - rtl/vga_timing.sv
      - rtl/byte_lane_ram.sv
      - rtl/glyph_pixel_pipe.sv
      - rtl/vgachargen.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/tb_clock_gen.sv
      - tests/vgachargen_checker.sv
      - tests/vgachargen_tb.sv
